// ==== logic/life_defs.svh ====
/* Sizes and timings for a 16x16 toroidal Life grid on a single clock.
   Times are in clk cycles and are scaled down for simulation */
`ifndef LIFE_DEFS_SVH
`define LIFE_DEFS_SVH

//////////////////////////////
// Grid geometry
//////////////////////////////
`define GRID_WIDTH 16 // Cells per row, also LFSR width
`define GRID_DEPTH 16 // Rows in the cell RAM
`define ROW_BITS 4 // Row address width

// Read address of a centre row to write of its new row
`define PIPE_DEPTH 6

// Wait after reset before the seed rows go in
`define INIT_WAIT 32

//////////////////////////////
// Fire button debounce
//////////////////////////////
`define DB_PRESS_CYCLES 5 // Steady high needed for a press
`define DB_PULSE_CYCLES 25 // End of the short pulse
`define DB_LONG_CYCLES 200 // Hold time to enter long state
`define DB_OFF_CYCLES 100 // Low time back to idle

// Scaled second for the rate counter
`define SECOND_CYCLES 2000

// Galois LFSR, shift right with mask applied on bit 0
`define LFSR_SEED 16'hACE1
`define LFSR_TAPS 16'hB400 // Taps 15 13 12 10

// Statistics widths
`define GEN_BITS 32
`define RATE_BITS 16

`endif

// ==== logic/life_pkg.sv ====
/* Shared types of the Life core. Widths come from the defs header */
`default_nettype none
`include "life_defs.svh"

package life_pkg;

	// One grid row, bit i is column i
	typedef logic [`GRID_WIDTH-1:0] cell_row_t;

	// Row index into the cell RAM
	typedef logic [`ROW_BITS-1:0] row_addr_t;

	// Fire button debouncer states
	typedef enum logic [2:0] {
		S_IDLE,
		S_WAIT_PRESS, // Qualifying the press
		S_WAIT_PULSE, // Short pulse out
		S_WAIT_LONG,
		S_LONG, // Held, hold level out
		S_WAIT_OFF, // Released before long
		S_WAIT_LOFF // Released from long
	} debounce_state_t;

endpackage

`default_nettype wire

// ==== logic/button_debounce.sv ====
/* Button may be asynchronous. Short pulse and hold level are both
   derived from one state machine so a long press also yields a pulse */
`timescale 1ns/10ps
`default_nettype none
`include "life_defs.svh"

module button_debounce
	import life_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic button,
	output logic fire_pulse,
	output logic fire_hold
);

	localparam int C1_BITS = $clog2(`DB_LONG_CYCLES + 1);
	localparam int C0_BITS = $clog2(`DB_OFF_CYCLES + 2);
	localparam logic [C1_BITS-1:0] PRESS_COUNT = `DB_PRESS_CYCLES;
	localparam logic [C1_BITS-1:0] PULSE_COUNT = `DB_PULSE_CYCLES;
	localparam logic [C1_BITS-1:0] LONG_COUNT = `DB_LONG_CYCLES;
	localparam logic [C0_BITS-1:0] OFF_COUNT = `DB_OFF_CYCLES;

	logic [2:0] sync; // Metastability chain
	logic in_s; // Synchronised button
	debounce_state_t state;
	logic [C1_BITS-1:0] count1; // Time since press began
	logic [C0_BITS-1:0] count0; // Time since release

	always_ff @(posedge clk) begin
		sync <= {sync[1:0], button};
	end
	assign in_s = sync[2];

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE:       state <= in_s ? S_WAIT_PRESS : S_IDLE;
				S_WAIT_PRESS: state <= !in_s ? S_IDLE :
					(count1 == PRESS_COUNT) ? S_WAIT_PULSE : S_WAIT_PRESS;
				S_WAIT_PULSE: state <= (count1 == PULSE_COUNT) ? S_WAIT_LONG : S_WAIT_PULSE;
				S_WAIT_LONG:  state <= !in_s ? S_WAIT_OFF :
					(count1 >= LONG_COUNT) ? S_LONG : S_WAIT_LONG;
				S_LONG:       state <= !in_s ? S_WAIT_LOFF : S_LONG;
				S_WAIT_OFF:   state <= in_s ? S_WAIT_LONG :
					(count0 == OFF_COUNT) ? S_IDLE : S_WAIT_OFF;
				S_WAIT_LOFF:  state <= in_s ? S_LONG :
					(count0 == OFF_COUNT) ? S_IDLE : S_WAIT_LOFF;
				default:      state <= S_IDLE;
			endcase
		end
	end

	// Press counter saturates so a bouncy release cannot wrap it
	always_ff @(posedge clk) begin
		if (reset) begin
			count1 <= '0;
			count0 <= '0;
		end else begin
			if (state == S_IDLE)
				count1 <= '0;
			else if (count1 != LONG_COUNT)
				count1 <= count1 + 1'b1;
			count0 <= (state == S_WAIT_OFF || state == S_WAIT_LOFF) ? count0 + 1'b1 : '0;
		end
	end

	assign fire_pulse = (state == S_WAIT_PULSE); // PULSE minus PRESS cycles wide
	assign fire_hold = (state == S_LONG) || (state == S_WAIT_LOFF);

endmodule

`default_nettype wire

// ==== logic/cell_ram.sv ====
/* Two-port row memory. Read data appears two cycles after the address.
   A read of a row in its write cycle returns the old row */
`timescale 1ns/10ps
`default_nettype none
`include "life_defs.svh"

module cell_ram
	import life_pkg::*;
(
	input  logic      clk,
	input  logic      wr_en,
	input  row_addr_t wr_addr,
	input  cell_row_t wr_row,
	input  row_addr_t rd_addr,
	output cell_row_t rd_row
);

	cell_row_t mem [`GRID_DEPTH]; // One word per grid row
	row_addr_t rd_addr_q; // Registered read address

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_row;
		end
		rd_addr_q <= rd_addr;
		rd_row <= mem[rd_addr_q]; // Output register
	end

endmodule

`default_nettype wire

// ==== logic/cell_engine.sv ====
/* One Life generation per pass with rows and columns wrapping.
   Expects the pass read order 15, 0..15, 0 from generation_control */
`timescale 1ns/10ps
`default_nettype none
`include "life_defs.svh"

module cell_engine
	import life_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      seeding,
	input  logic      seed_we,
	input  row_addr_t seed_addr,
	input  cell_row_t seed_row,
	input  row_addr_t rd_addr,
	input  row_addr_t wr_addr,
	input  logic      wr_en,
	input  logic      window_shift,
	input  logic      row_load,
	output cell_row_t row_data,
	output logic      row_valid
);

	logic ram_we;
	row_addr_t ram_wr_addr;
	cell_row_t ram_wr_row;
	cell_row_t rd_row;
	row_addr_t rd_addr_q, rd_addr_qq; // Tracks rd_row's address
	cell_row_t wrap_row; // Row 0 before this pass wrote it
	logic wrap_valid;
	logic wrap_hit;
	cell_row_t in_row;
	cell_row_t win_top, win_mid, win_bot; // Three-row window, top is oldest
	logic [`GRID_WIDTH-1:0][1:0] col_sum;
	logic [`GRID_WIDTH-1:0][1:0] col_sum_q;
	logic [`GRID_WIDTH-1:0][3:0] total; // 3x3 count including self
	cell_row_t next_row;
	cell_row_t new_row; // Registered result, feeds the write port

	// Seed rows own the write port until seeding ends
	assign ram_we = seeding ? seed_we : wr_en;
	assign ram_wr_addr = seeding ? seed_addr : wr_addr;
	assign ram_wr_row = seeding ? seed_row : new_row;

	cell_ram cell_ram_inst (
		.clk    (clk),
		.wr_en  (ram_we),
		.wr_addr(ram_wr_addr),
		.wr_row (ram_wr_row),
		.rd_addr(rd_addr),
		.rd_row (rd_row)
	);

	//////////////////////////////
	// Window and wrap row
	//////////////////////////////

	// Row 0 is rewritten before its second read in a pass
	assign wrap_hit = (rd_addr_qq == '0) && wrap_valid;
	assign in_row = wrap_hit ? wrap_row : rd_row;

	always_ff @(posedge clk) begin
		rd_addr_q <= rd_addr;
		rd_addr_qq <= rd_addr_q;
		if (window_shift) begin
			win_top <= win_mid;
			win_mid <= win_bot;
			win_bot <= in_row;
			col_sum_q <= col_sum; // Sums of top mid bot, mid moves to top
			new_row <= next_row;
			if (rd_addr_qq == '0 && !wrap_valid)
				wrap_row <= rd_row; // First read of row 0
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			wrap_valid <= 1'b0;
		else if (window_shift && rd_addr_qq == '0)
			wrap_valid <= !wrap_valid; // Alternates per read of row 0
	end

	//////////////////////////////
	// Neighbour sums and rule
	//////////////////////////////
	always_comb begin
		for (int i = 0; i < `GRID_WIDTH; i++) begin
			col_sum[i] = {1'b0, win_top[i]} + {1'b0, win_mid[i]} + {1'b0, win_bot[i]};
		end
		for (int i = 0; i < `GRID_WIDTH; i++) begin
			total[i] = {2'b00, col_sum_q[(i + 1) % `GRID_WIDTH]} + {2'b00, col_sum_q[i]}
				+ {2'b00, col_sum_q[(i + `GRID_WIDTH - 1) % `GRID_WIDTH]};
			// Top now holds the centre row
			next_row[i] = (total[i] == 4'd3) || (total[i] == 4'd4 && win_top[i]);
		end
	end

	// Row read port for the host
	always_ff @(posedge clk) begin
		if (row_load)
			row_data <= rd_row;
	end

	always_ff @(posedge clk) begin
		if (reset)
			row_valid <= 1'b0;
		else
			row_valid <= row_load; // Same cycle row_data updates
	end

endmodule

`default_nettype wire

// ==== logic/grid_seeder.sv ====
/* Seeds each row once after reset with one LFSR step per row.
   Stays idle afterwards until the next reset */
`timescale 1ns/10ps
`default_nettype none
`include "life_defs.svh"

module grid_seeder
	import life_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	output logic      seed_we,
	output row_addr_t seed_addr,
	output cell_row_t seed_row,
	output logic      seeding
);

	localparam int CNT_BITS = $clog2(`INIT_WAIT + `GRID_DEPTH + 1);
	localparam logic [CNT_BITS-1:0] SEED_START = `INIT_WAIT;
	localparam logic [CNT_BITS-1:0] SEED_STOP = `INIT_WAIT + `GRID_DEPTH;

	logic [CNT_BITS-1:0] init_count; // Stops at SEED_STOP
	logic [CNT_BITS-1:0] seed_index;
	cell_row_t lfsr;

	always_ff @(posedge clk) begin
		if (reset)
			init_count <= '0;
		else if (init_count != SEED_STOP)
			init_count <= init_count + 1'b1;
	end

	assign seeding = (init_count != SEED_STOP);
	assign seed_we = seeding && (init_count >= SEED_START); // One row per cycle
	assign seed_index = init_count - SEED_START;
	assign seed_addr = seed_index[`ROW_BITS-1:0];

	// Galois step, bit 0 feeds bit 15 and the tap bits
	always_ff @(posedge clk) begin
		if (reset)
			lfsr <= `LFSR_SEED;
		else if (seed_we)
			lfsr <= (lfsr >> 1) ^ ({`GRID_WIDTH{lfsr[0]}} & `LFSR_TAPS);
	end
	assign seed_row = lfsr;

endmodule

`default_nettype wire

// ==== logic/generation_control.sv ====
/* Pass sequencer. Fire is ignored while seeding and a pending row read
   stops a held fire from chaining passes until the read is served */
`timescale 1ns/10ps
`default_nettype none
`include "life_defs.svh"

module generation_control
	import life_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      fire_pulse,
	input  logic      fire_hold,
	input  logic      seeding,
	input  logic      row_req,
	input  row_addr_t row_addr,
	output row_addr_t rd_addr,
	output row_addr_t wr_addr,
	output logic      wr_en,
	output logic      window_shift,
	output logic      row_load,
	output logic      busy,
	output logic      pass_done
);

	localparam int PASS_BITS = `ROW_BITS + 1;
	localparam logic [PASS_BITS-1:0] IDLE_COUNT = '1;
	localparam logic [PASS_BITS-1:0] START_COUNT = '0;
	localparam logic [PASS_BITS-1:0] DONE_COUNT = `GRID_DEPTH + `PIPE_DEPTH;
	localparam logic [PASS_BITS-1:0] WR_OFFSET = `PIPE_DEPTH + 1;

	logic [PASS_BITS-1:0] pass_count; // Step in pass or IDLE_COUNT
	logic [PASS_BITS-1:0] rd_step, wr_step;
	logic pulse_d;
	logic fire_shot; // One cycle per debounced press
	logic go;
	logic idle;
	logic read_pend;
	row_addr_t pend_addr;
	logic service; // Pending row read gets the RAM this cycle
	logic [1:0] shift_del, load_del; // Match the RAM read latency

	assign fire_shot = fire_pulse & ~pulse_d;
	assign go = (fire_shot | fire_hold) & ~seeding;
	assign idle = (pass_count == IDLE_COUNT);
	assign service = idle & read_pend;
	assign busy = ~idle;

	// Step 0 reads row 15, steps 1..16 rows 0..15, step 17 row 0
	assign rd_step = pass_count - 1'b1;
	assign rd_addr = idle ? pend_addr : rd_step[`ROW_BITS-1:0];
	assign wr_step = pass_count - WR_OFFSET; // Centre row read PIPE_DEPTH ago
	assign wr_addr = wr_step[`ROW_BITS-1:0];
	assign wr_en = (pass_count >= WR_OFFSET) && (pass_count <= DONE_COUNT);

	always_ff @(posedge clk) begin
		if (reset) begin
			pass_count <= IDLE_COUNT;
			pulse_d <= 1'b0;
			read_pend <= 1'b0;
			pass_done <= 1'b0;
			shift_del <= '0;
			load_del <= '0;
		end else begin
			pulse_d <= fire_pulse;
			if (idle)
				pass_count <= go ? START_COUNT : IDLE_COUNT;
			else if (pass_count == DONE_COUNT) // Chain with no gap while held
				pass_count <= (fire_hold && !read_pend && !seeding) ? START_COUNT : IDLE_COUNT;
			else
				pass_count <= pass_count + 1'b1;
			if (row_req)
				read_pend <= 1'b1;
			else if (service)
				read_pend <= 1'b0;
			pass_done <= (pass_count == DONE_COUNT);
			shift_del <= {shift_del[0], busy};
			load_del <= {load_del[0], service};
		end
	end

	always_ff @(posedge clk) begin
		if (row_req)
			pend_addr <= row_addr;
	end

	assign window_shift = shift_del[1]; // Pass reads arriving from RAM
	assign row_load = load_del[1];

endmodule

`default_nettype wire

// ==== logic/generation_stats.sv ====
/* Counts finished passes. The per-second rate uses the scaled second
   and shows the last complete window only */
`timescale 1ns/10ps
`default_nettype none
`include "life_defs.svh"

module generation_stats (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  pass_done,
	output logic [`GEN_BITS-1:0]  gen_count,
	output logic [`RATE_BITS-1:0] gens_per_sec
);

	localparam int SEC_BITS = $clog2(`SECOND_CYCLES);
	localparam logic [SEC_BITS-1:0] SEC_LAST = `SECOND_CYCLES - 1;

	logic [SEC_BITS-1:0] sec_count; // Free running
	logic sec_tick;
	logic [`RATE_BITS-1:0] window_count; // Passes in current second

	assign sec_tick = (sec_count == SEC_LAST);

	always_ff @(posedge clk) begin
		if (reset) begin
			sec_count <= '0;
			gen_count <= '0;
			window_count <= '0;
			gens_per_sec <= '0;
		end else begin
			sec_count <= sec_tick ? '0 : sec_count + 1'b1;
			if (pass_done)
				gen_count <= gen_count + 1'b1;
			if (sec_tick) begin
				gens_per_sec <= window_count;
				// A pass ending on the tick opens the next window
				window_count <= {{(`RATE_BITS-1){1'b0}}, pass_done};
			end else if (pass_done) begin
				window_count <= window_count + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/life_top.sv ====
/* Life core top on one clock. Row reads wait for any running pass
   so row_valid latency varies */
`timescale 1ns/10ps
`default_nettype none
`include "life_defs.svh"

module life_top
	import life_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  fire_button,
	input  logic                  row_req,
	input  row_addr_t             row_addr,
	output cell_row_t             row_data,
	output logic                  row_valid,
	output logic                  busy,
	output logic                  seeding,
	output logic [`GEN_BITS-1:0]  gen_count,
	output logic [`RATE_BITS-1:0] gens_per_sec
);

	logic fire_pulse, fire_hold;
	logic seed_we;
	row_addr_t seed_addr;
	cell_row_t seed_row;
	row_addr_t rd_addr, wr_addr;
	logic wr_en, window_shift, row_load;
	logic pass_done;

	button_debounce button_debounce_inst (
		.clk(clk), .reset(reset), .button(fire_button),
		.fire_pulse(fire_pulse), .fire_hold(fire_hold)
	);

	grid_seeder grid_seeder_inst (
		.clk(clk), .reset(reset), .seed_we(seed_we),
		.seed_addr(seed_addr), .seed_row(seed_row), .seeding(seeding)
	);

	generation_control generation_control_inst (
		.clk(clk), .reset(reset), .fire_pulse(fire_pulse), .fire_hold(fire_hold),
		.seeding(seeding), .row_req(row_req), .row_addr(row_addr),
		.rd_addr(rd_addr), .wr_addr(wr_addr), .wr_en(wr_en),
		.window_shift(window_shift), .row_load(row_load),
		.busy(busy), .pass_done(pass_done)
	);

	cell_engine cell_engine_inst (
		.clk(clk), .reset(reset), .seeding(seeding), .seed_we(seed_we),
		.seed_addr(seed_addr), .seed_row(seed_row), .rd_addr(rd_addr),
		.wr_addr(wr_addr), .wr_en(wr_en), .window_shift(window_shift),
		.row_load(row_load), .row_data(row_data), .row_valid(row_valid)
	);

	generation_stats generation_stats_inst (
		.clk(clk), .reset(reset), .pass_done(pass_done),
		.gen_count(gen_count), .gens_per_sec(gens_per_sec)
	);

endmodule

`default_nettype wire

// ==== test/life_asserts.sv ====
/* Pass sequencer checks, bound into generation_control.
   Clocked on clk, quiet while reset is high except the reset check */
`timescale 1ns/10ps
`default_nettype none
`include "life_defs.svh"

module life_asserts (
	input logic clk,
	input logic reset,
	input logic seeding,
	input logic wr_en,
	input logic busy,
	input logic pass_done
);

	localparam int PASS_CYCLES = `GRID_DEPTH + `PIPE_DEPTH + 1; // Start to done pulse

	// Seed rows own the RAM write port
	property no_write_while_seeding;
		@(posedge clk) disable iff (reset) !(wr_en && seeding);
	endproperty

	// Done pulse closes a pass that held busy from its start
	property done_after_busy;
		@(posedge clk) disable iff (reset)
			pass_done |-> $past(busy) && $past(busy, PASS_CYCLES);
	endproperty

	// First pass of a run ends exactly one pass length later
	property pass_length;
		@(posedge clk) disable iff (reset) $rose(busy) |-> ##PASS_CYCLES pass_done;
	endproperty

	property idle_after_reset;
		@(posedge clk) reset |=> !busy;
	endproperty

	assert property (no_write_while_seeding)
		else $error("wr_en high while seeding");
	assert property (done_after_busy)
		else $error("pass_done without busy through the whole pass");
	assert property (pass_length)
		else $error("pass_done not one pass length after busy rose");
	assert property (idle_after_reset)
		else $error("busy high in the cycle after reset");

endmodule

bind generation_control life_asserts life_asserts_inst (
	.clk(clk), .reset(reset), .seeding(seeding),
	.wr_en(wr_en), .busy(busy), .pass_done(pass_done)
);

`default_nettype wire

// ==== test/life_tb.sv ====
/* Directed tests of the Life core against a model of the seed LFSR and the
   toroidal rule. Times come from the defs header, no random stimulus */
`timescale 1ns/10ps
`default_nettype none
`include "life_defs.svh"

module life_tb
	import life_pkg::*;
();

	localparam int PASS_CYCLES = `GRID_DEPTH + `PIPE_DEPTH + 1;
	localparam int WAIT_LIMIT = 1000; // Longest any single wait may run
	localparam int QUIET_CYCLES = 40; // Idle span that ends a held run

	logic clk;
	logic reset;
	logic fire_button;
	logic row_req;
	row_addr_t row_addr;
	cell_row_t row_data;
	logic row_valid;
	logic busy;
	logic seeding;
	logic [`GEN_BITS-1:0] gen_count;
	logic [`RATE_BITS-1:0] gens_per_sec;

	cell_row_t model_grid [`GRID_DEPTH]; // Expected grid

	life_top life_top_inst (
		.clk(clk), .reset(reset), .fire_button(fire_button),
		.row_req(row_req), .row_addr(row_addr), .row_data(row_data),
		.row_valid(row_valid), .busy(busy), .seeding(seeding),
		.gen_count(gen_count), .gens_per_sec(gens_per_sec)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	// Drive and sample 1 ns after the rising edge
	task automatic advance_cycle;
		@(posedge clk);
		#1;
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		if (exp !== got)
			report_failure($sformatf("MISMATCH %s exp %h got %h", name, exp, got));
	endtask

	task automatic wait_for_busy(input logic level);
		int n;
		n = 0;
		while (busy !== level) begin
			advance_cycle;
			n++;
			if (n > WAIT_LIMIT)
				report_failure($sformatf("Timed out waiting for busy to go %0b", level));
		end
	endtask

	task automatic wait_for_gen_count(input logic [31:0] value);
		int n;
		n = 0;
		while (gen_count !== value) begin
			advance_cycle;
			n++;
			if (n > WAIT_LIMIT)
				report_failure($sformatf("Timed out waiting for gen_count to reach %0d", value));
		end
	endtask

	// Busy must stay low for a while, so chained passes have stopped
	task automatic wait_until_quiet;
		int n;
		int low;
		n = 0;
		low = 0;
		while (low < QUIET_CYCLES) begin
			advance_cycle;
			low = busy ? 0 : low + 1;
			n++;
			if (n > WAIT_LIMIT)
				report_failure("Passes kept running long after the button was released");
		end
	endtask

	task automatic read_row(input int r, output cell_row_t data);
		int n;
		row_req = 1'b1;
		row_addr = r[`ROW_BITS-1:0];
		advance_cycle;
		row_req = 1'b0;
		n = 0;
		while (row_valid !== 1'b1) begin
			advance_cycle;
			n++;
			if (n > WAIT_LIMIT)
				report_failure($sformatf("Timed out waiting for row_valid on row %0d", r));
		end
		data = row_data;
	endtask

	task automatic compare_grid;
		cell_row_t got;
		for (int r = 0; r < `GRID_DEPTH; r++) begin
			read_row(r, got);
			check_value($sformatf("row_data[%0d]", r), model_grid[r], got);
		end
	endtask

	task automatic press_button(input int cycles);
		fire_button = 1'b1;
		repeat (cycles) advance_cycle;
		fire_button = 1'b0;
	endtask

	// Debouncer back to idle after a short press
	task automatic settle_button;
		repeat (`DB_PULSE_CYCLES + `DB_OFF_CYCLES + 10) advance_cycle;
	endtask

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// Row k holds the LFSR after k right shifts from the seed
	task automatic build_seed_model;
		cell_row_t lfsr;
		logic fb;
		lfsr = `LFSR_SEED;
		for (int r = 0; r < `GRID_DEPTH; r++) begin
			model_grid[r] = lfsr;
			fb = lfsr[0];
			lfsr = lfsr >> 1;
			if (fb)
				lfsr = lfsr ^ `LFSR_TAPS; // Mask has bit 15, old bit 0 lands there
		end
	endtask

	// Conway step, both axes wrap
	task automatic life_step_model;
		cell_row_t next_grid [`GRID_DEPTH];
		int n;
		int rr;
		int cc;
		for (int r = 0; r < `GRID_DEPTH; r++) begin
			for (int c = 0; c < `GRID_WIDTH; c++) begin
				n = 0;
				for (int dr = -1; dr <= 1; dr++) begin
					for (int dc = -1; dc <= 1; dc++) begin
						rr = (r + dr + `GRID_DEPTH) % `GRID_DEPTH;
						cc = (c + dc + `GRID_WIDTH) % `GRID_WIDTH;
						if ((dr != 0 || dc != 0) && model_grid[rr][cc])
							n++;
					end
				end
				if (model_grid[r][c])
					next_grid[r][c] = (n == 2) || (n == 3); // Survives
				else
					next_grid[r][c] = (n == 3); // Birth
			end
		end
		for (int r = 0; r < `GRID_DEPTH; r++)
			model_grid[r] = next_grid[r];
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////
	task automatic reset_and_seed;
		int n;
		check_value("busy", 0, busy);
		check_value("row_valid", 0, row_valid);
		check_value("gen_count", 0, gen_count);
		check_value("seeding", 1, seeding); // Seeder starts its wait at reset
		n = 0;
		while (seeding !== 1'b0) begin
			advance_cycle;
			n++;
			if (n > WAIT_LIMIT)
				report_failure("Seeding never finished after reset");
		end
		build_seed_model;
		compare_grid;
	endtask

	task automatic short_press;
		press_button(30); // Past the pulse, well short of long
		wait_for_gen_count(1);
		wait_for_busy(1'b0);
		life_step_model;
		compare_grid;
		settle_button;
	endtask

	task automatic read_during_pass;
		cell_row_t got;
		logic went_idle;
		int n;
		fire_button = 1'b1;
		wait_for_busy(1'b1);
		row_req = 1'b1; // Request lands mid pass
		row_addr = 4'd7;
		fire_button = 1'b0;
		advance_cycle;
		row_req = 1'b0;
		went_idle = 1'b0;
		n = 0;
		while (row_valid !== 1'b1) begin
			if (!busy)
				went_idle = 1'b1;
			advance_cycle;
			n++;
			if (n > WAIT_LIMIT)
				report_failure("Timed out waiting for row_valid on a read issued during a pass");
		end
		if (!went_idle)
			report_failure("row_valid arrived while the pass was still running");
		got = row_data;
		life_step_model;
		check_value("row_data[7]", model_grid[7], got);
		wait_for_gen_count(2);
		compare_grid;
		settle_button;
	endtask

	task automatic long_hold;
		logic [31:0] start_count;
		int steps;
		start_count = gen_count;
		press_button(`DB_LONG_CYCLES + 50);
		wait_until_quiet;
		steps = int'(gen_count - start_count);
		if (steps < 2)
			report_failure($sformatf("Long hold gave only %0d generations", steps));
		for (int i = 0; i < steps; i++)
			life_step_model;
		compare_grid;
	endtask

	task automatic generation_rate;
		logic [`RATE_BITS-1:0] rate;
		int exp_rate;
		exp_rate = `SECOND_CYCLES / PASS_CYCLES;
		fire_button = 1'b1;
		// Last latched window lies fully inside the chained run
		repeat (`DB_LONG_CYCLES + 2 * `SECOND_CYCLES + 100) advance_cycle;
		rate = gens_per_sec;
		fire_button = 1'b0;
		if (rate < exp_rate - 1 || rate > exp_rate + 1)
			report_failure($sformatf("MISMATCH gens_per_sec exp %h got %h", exp_rate, rate));
		wait_until_quiet;
	endtask

	initial begin
		reset = 1'b1;
		fire_button = 1'b0;
		row_req = 1'b0;
		row_addr = '0;
		repeat (5) advance_cycle;
		reset = 1'b0;
		reset_and_seed;
		short_press;
		read_during_pass;
		long_hold;
		generation_rate;
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+logic
logic/life_pkg.sv
logic/button_debounce.sv
logic/cell_ram.sv
logic/cell_engine.sv
logic/grid_seeder.sv
logic/generation_control.sv
logic/generation_stats.sv
logic/life_top.sv
test/life_asserts.sv
test/life_tb.sv

// ==== Bender.yml ====
package:
  name: life_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/life_pkg.sv
      - logic/button_debounce.sv
      - logic/cell_ram.sv
      - logic/cell_engine.sv
      - logic/grid_seeder.sv
      - logic/generation_control.sv
      - logic/generation_stats.sv
      - logic/life_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/life_asserts.sv
      - test/life_tb.sv
